// ==== hw/cart_pkg.sv ====
package cart_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // snes side byte address
  localparam int snes_addr_w = 24;
  // psram word address, 16 bit words
  localparam int rom_addr_w = 23;

  // delay counter load on grant, access state lasts this plus one
  localparam logic [3:0] rom_cycle_len = 4'd6;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // raw request from one requester
  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    logic [snes_addr_w-1:0] addr;
    byte_t                  wdata;
  } rom_req_t;

  // latched request, held until the fsm finishes it
  typedef struct packed {
    logic                   rd_pend;
    logic                   wr_pend;
    logic [snes_addr_w-1:0] addr;
    byte_t                  wdata;
  } rom_pend_t;

  // conditioned snes bus events, one cycle strobes except dead
  typedef struct packed {
    logic cycle_start;
    logic cycle_end;
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic free_slot;
    logic dead;
  } snes_evt_t;

  // rom cycle states
  typedef enum logic [2:0] {
    st_idle,
    st_mcu_rd,
    st_mcu_wr,
    st_gsu_rd,
    st_gsu_wr,
    st_mcu_end,
    st_gsu_end
  } rom_state_e;

endpackage

// ==== hw/snes_bus_sync.sv ====
`timescale 1ns/1ps

module snes_bus_sync #(
  parameter int sync_depth   = 8,
  parameter int dead_timeout = 96000
) (
  input  logic                             CLK2,
  input  logic                             reset,
  input  logic                             snes_cpu_clk,
  input  logic                             snes_rd_n,
  input  logic                             snes_wr_n,
  input  logic                             rom_hit,
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr,
  output cart_pkg::snes_evt_t              evt,
  output logic [cart_pkg::snes_addr_w-1:0] addr_sync,
  output logic                             cpu_clk_live,
  output logic                             reset_strobe
);

  // decode window, two overlapping taps of this width
  localparam int win   = sync_depth - 2;
  localparam int cnt_w = $clog2(dead_timeout + 2);

  // newest samples sit in the low bits
  localparam logic [win-1:0] pat_cyc_start = {{(win - 2){1'b0}}, 2'b11};
  localparam logic [win-1:0] pat_cyc_end   = {{(win / 2){1'b1}}, {(win - win / 2){1'b0}}};
  localparam logic [win-1:0] pat_rd_start  = {{(win - 2){1'b1}}, 2'b00};
  localparam logic [win-1:0] pat_rise_one  = {{(win - 1){1'b0}}, 1'b1};

  logic [sync_depth-1:0]            clk_sr;
  logic [sync_depth-1:0]            rd_sr;
  logic [sync_depth-1:0]            wr_sr;
  logic [cart_pkg::snes_addr_w-1:0] addr_sr [sync_depth-1];
  logic                             cycle_start;
  logic                             cycle_end;
  logic                             rd_start;
  logic                             rd_end_q;
  logic                             wr_end_q;
  logic                             free_strobe;
  logic [cnt_w-1:0]                 dead_cnt;
  logic                             dead_q;

  ////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////

  // clock idles low, strobes idle high
  always_ff @(posedge CLK2) begin
    if (reset) begin
      clk_sr <= '0;
      rd_sr  <= '1;
      wr_sr  <= '1;
    end else begin
      clk_sr <= {clk_sr[sync_depth-2:0], snes_cpu_clk};
      rd_sr  <= {rd_sr[sync_depth-2:0], snes_rd_n};
      wr_sr  <= {wr_sr[sync_depth-2:0], snes_wr_n};
    end
  end

  // address pipe, settles alongside the control decode
  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < sync_depth - 1; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // and of two taps drops single sample spikes
  assign addr_sync    = addr_sr[sync_depth-2] & addr_sr[sync_depth-3];
  assign cpu_clk_live = clk_sr[1];

  ////////////////////////////////////////
  // edge strobes
  ////////////////////////////////////////

  // and / or of shifted windows masks short glitches
  assign cycle_start = ((clk_sr[win+1:2] & clk_sr[win:1]) == pat_cyc_start);
  assign cycle_end   = ((clk_sr[win+1:2] | clk_sr[win:1]) == pat_cyc_end);
  assign rd_start    = ((rd_sr[win:1] | rd_sr[win+1:2]) == pat_rd_start);

  // end strobes one cycle later than the raw window match
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_end_q <= 1'b0;
      wr_end_q <= 1'b0;
    end else begin
      rd_end_q <= ((rd_sr[win-1:0] & rd_sr[win:1]) == pat_rise_one);
      wr_end_q <= ((wr_sr[win-1:0] & wr_sr[win:1]) == pat_rise_one);
    end
  end

  // cycle not aimed at rom, slot is free right after its start
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  ////////////////////////////////////////
  // dead watchdog
  ////////////////////////////////////////

  // saturates one past the timeout
  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
    end else if (clk_sr[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= cnt_w'(dead_timeout)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  // clock back after dead gives one reset pulse
  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_q       <= 1'b1;
      reset_strobe <= 1'b0;
    end else begin
      reset_strobe <= 1'b0;
      if (clk_sr[1]) begin
        dead_q <= 1'b0;
        if (dead_q) begin
          reset_strobe <= 1'b1;
        end
      end else if (dead_cnt > cnt_w'(dead_timeout)) begin
        dead_q <= 1'b1;
      end
    end
  end

  assign evt = '{
    cycle_start: cycle_start,
    cycle_end:   cycle_end,
    rd_start:    rd_start,
    rd_end:      rd_end_q,
    wr_end:      wr_end_q,
    free_slot:   cycle_end | free_strobe,
    dead:        dead_q
  };

endmodule

// ==== hw/rom_req_port.sv ====
`timescale 1ns/1ps

module rom_req_port (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::rom_req_t  req,
  input  logic                done,
  input  logic                capture,
  input  cart_pkg::byte_t     lane_byte,
  output cart_pkg::rom_pend_t pend,
  output logic                rdy,
  output cart_pkg::byte_t     rdata
);

  logic                             rd_pend_q;
  logic                             wr_pend_q;
  logic                             rdy_q;
  logic [cart_pkg::snes_addr_w-1:0] addr_q;
  cart_pkg::byte_t                  wdata_q;
  cart_pkg::byte_t                  rdata_q;

  ////////////////////////////////////////
  // pending flags and ready
  ////////////////////////////////////////

  // strobe wins over done, strobe only legal while ready
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      rdy_q     <= 1'b1;
    end else if (req.rrq) begin
      rd_pend_q <= 1'b1;
      rdy_q     <= 1'b0;
    end else if (req.wrq) begin
      wr_pend_q <= 1'b1;
      rdy_q     <= 1'b0;
    end else if (done) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      rdy_q     <= 1'b1;
    end
  end

  // request payload, taken with either strobe
  always_ff @(posedge CLK2) begin
    if (req.rrq || req.wrq) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
  end

  // read data, last capture of the access state stays
  always_ff @(posedge CLK2) begin
    if (capture) begin
      rdata_q <= lane_byte;
    end
  end

  assign pend = '{
    rd_pend: rd_pend_q,
    wr_pend: wr_pend_q,
    addr:    addr_q,
    wdata:   wdata_q
  };

  assign rdy   = rdy_q;
  assign rdata = rdata_q;

endmodule

// ==== hw/rom_cycle_fsm.sv ====
`timescale 1ns/1ps

module rom_cycle_fsm (
  input  logic                             CLK2,
  input  logic                             reset,
  input  cart_pkg::snes_evt_t              evt,
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr,
  input  cart_pkg::rom_pend_t              mcu_pend,
  input  cart_pkg::rom_pend_t              gsu_pend,
  input  logic                             gsu_active,
  input  logic                             cpu_clk_live,
  input  cart_pkg::rom_word_t              rom_rdata,
  output logic [cart_pkg::rom_addr_w-1:0]  rom_addr,
  output cart_pkg::rom_word_t              rom_wdata,
  output logic                             rom_wdata_en,
  output logic                             rom_we_n,
  output logic                             rom_bhe_n,
  output logic                             rom_ble_n,
  output logic                             mcu_done,
  output logic                             gsu_done,
  output logic                             mcu_capture,
  output logic                             gsu_capture,
  output cart_pkg::byte_t                  lane_byte,
  output cart_pkg::byte_t                  snes_rdata
);

  cart_pkg::rom_state_e             state_q;
  cart_pkg::rom_state_e             grant;
  logic [3:0]                       delay_q;
  logic                             mcu_hit;
  logic                             gsu_hit;
  logic                             wr_hit;
  logic [cart_pkg::snes_addr_w-1:0] sel_addr;
  logic                             lane_lo;
  cart_pkg::byte_t                  wr_byte;

  ////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////

  // gsu owns the bus while active, mcu waits for a slot
  always_comb begin
    grant = cart_pkg::st_idle;
    if (gsu_active) begin
      if (gsu_pend.rd_pend) begin
        grant = cart_pkg::st_gsu_rd;
      end else if (gsu_pend.wr_pend) begin
        grant = cart_pkg::st_gsu_wr;
      end
    end else if (evt.free_slot || evt.dead) begin
      if (mcu_pend.rd_pend) begin
        grant = cart_pkg::st_mcu_rd;
      end else if (mcu_pend.wr_pend) begin
        grant = cart_pkg::st_mcu_wr;
      end
    end
  end

  // snes waking up aborts the access, request stays pending
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state_q <= cart_pkg::st_idle;
      delay_q <= '0;
    end else if (evt.dead && cpu_clk_live) begin
      state_q <= cart_pkg::st_idle;
    end else begin
      case (state_q)
        cart_pkg::st_idle: begin
          if (grant != cart_pkg::st_idle) begin
            state_q <= grant;
            delay_q <= cart_pkg::rom_cycle_len;
          end
        end
        cart_pkg::st_mcu_rd, cart_pkg::st_mcu_wr,
        cart_pkg::st_gsu_rd, cart_pkg::st_gsu_wr: begin
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0) begin
            state_q <= mcu_hit ? cart_pkg::st_mcu_end : cart_pkg::st_gsu_end;
          end
        end
        default: begin
          state_q <= cart_pkg::st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // address and lanes
  ////////////////////////////////////////

  assign mcu_hit = (state_q == cart_pkg::st_mcu_rd) || (state_q == cart_pkg::st_mcu_wr);
  assign gsu_hit = (state_q == cart_pkg::st_gsu_rd) || (state_q == cart_pkg::st_gsu_wr);
  assign wr_hit  = (state_q == cart_pkg::st_mcu_wr) || (state_q == cart_pkg::st_gsu_wr);

  // snes address whenever no requester holds the bus
  assign sel_addr = gsu_hit ? gsu_pend.addr : mcu_hit ? mcu_pend.addr : snes_addr;
  assign rom_addr = sel_addr[cart_pkg::snes_addr_w-1:1];

  // odd byte address is the low lane
  assign lane_lo   = sel_addr[0];
  assign rom_ble_n = ~lane_lo;
  assign rom_bhe_n = lane_lo;

  assign lane_byte  = lane_lo ? rom_rdata[7:0] : rom_rdata[15:8];
  assign snes_rdata = lane_byte;

  // write byte on its own lane only
  assign wr_byte      = gsu_hit ? gsu_pend.wdata : mcu_pend.wdata;
  assign rom_wdata    = lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_wdata_en = wr_hit;
  assign rom_we_n     = ~wr_hit;

  // port handshakes
  assign mcu_done    = (state_q == cart_pkg::st_mcu_end);
  assign gsu_done    = (state_q == cart_pkg::st_gsu_end);
  assign mcu_capture = (state_q == cart_pkg::st_mcu_rd);
  assign gsu_capture = (state_q == cart_pkg::st_gsu_rd);

endmodule

// ==== hw/cart_main.sv ====
`timescale 1ns/1ps

module cart_main #(
  parameter int dead_timeout = 96000,
  parameter int sync_depth   = 8
) (
  input  logic                             CLK2,
  input  logic                             reset,

  // snes bus, mapper result
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr,
  input  logic                             snes_cpu_clk,
  input  logic                             snes_rd_n,
  input  logic                             snes_wr_n,
  input  logic                             rom_hit,
  output cart_pkg::byte_t                  snes_rdata,
  output logic                             snes_reset_strobe,

  // requesters
  input  cart_pkg::rom_req_t               mcu_req,
  input  cart_pkg::rom_req_t               gsu_req,
  input  logic                             gsu_active,
  output logic                             mcu_rdy,
  output logic                             gsu_rdy,
  output cart_pkg::byte_t                  mcu_rdata,
  output cart_pkg::byte_t                  gsu_rdata,

  // psram
  input  cart_pkg::rom_word_t              rom_rdata,
  output logic [cart_pkg::rom_addr_w-1:0]  rom_addr,
  output cart_pkg::rom_word_t              rom_wdata,
  output logic                             rom_wdata_en,
  output logic                             rom_we_n,
  output logic                             rom_bhe_n,
  output logic                             rom_ble_n
);

  cart_pkg::snes_evt_t              evt;
  logic [cart_pkg::snes_addr_w-1:0] addr_sync;
  logic                             cpu_clk_live;
  cart_pkg::rom_pend_t              mcu_pend;
  cart_pkg::rom_pend_t              gsu_pend;
  logic                             mcu_done;
  logic                             gsu_done;
  logic                             mcu_capture;
  logic                             gsu_capture;
  cart_pkg::byte_t                  lane_byte;

  ////////////////////////////////////////
  // snes input side
  ////////////////////////////////////////

  snes_bus_sync #(
    .sync_depth   (sync_depth),
    .dead_timeout (dead_timeout)
  ) u_bus_sync (
    .CLK2         (CLK2),
    .reset        (reset),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .rom_hit      (rom_hit),
    .snes_addr    (snes_addr),
    .evt          (evt),
    .addr_sync    (addr_sync),
    .cpu_clk_live (cpu_clk_live),
    .reset_strobe (snes_reset_strobe)
  );

  ////////////////////////////////////////
  // request ports
  ////////////////////////////////////////

  rom_req_port u_mcu_port (
    .CLK2      (CLK2),
    .reset     (reset),
    .req       (mcu_req),
    .done      (mcu_done),
    .capture   (mcu_capture),
    .lane_byte (lane_byte),
    .pend      (mcu_pend),
    .rdy       (mcu_rdy),
    .rdata     (mcu_rdata)
  );

  rom_req_port u_gsu_port (
    .CLK2      (CLK2),
    .reset     (reset),
    .req       (gsu_req),
    .done      (gsu_done),
    .capture   (gsu_capture),
    .lane_byte (lane_byte),
    .pend      (gsu_pend),
    .rdy       (gsu_rdy),
    .rdata     (gsu_rdata)
  );

  // arbiter and timed rom cycle
  rom_cycle_fsm u_rom_fsm (
    .CLK2         (CLK2),
    .reset        (reset),
    .evt          (evt),
    .snes_addr    (addr_sync),
    .mcu_pend     (mcu_pend),
    .gsu_pend     (gsu_pend),
    .gsu_active   (gsu_active),
    .cpu_clk_live (cpu_clk_live),
    .rom_rdata    (rom_rdata),
    .rom_addr     (rom_addr),
    .rom_wdata    (rom_wdata),
    .rom_wdata_en (rom_wdata_en),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n),
    .mcu_done     (mcu_done),
    .gsu_done     (gsu_done),
    .mcu_capture  (mcu_capture),
    .gsu_capture  (gsu_capture),
    .lane_byte    (lane_byte),
    .snes_rdata   (snes_rdata)
  );

endmodule

// ==== bench/cart_main_sva.sv ====
`timescale 1ns/1ps

module cart_main_sva (
  input logic                 CLK2,
  input logic                 reset,
  input logic                 strobe,
  input logic                 rdy,
  input cart_pkg::rom_state_e state,
  input logic                 we_n,
  input logic                 wr_pend
);

  logic wr_state;
  logic end_state;

  assign wr_state  = (state == cart_pkg::st_mcu_wr) || (state == cart_pkg::st_gsu_wr);
  assign end_state = (state == cart_pkg::st_mcu_end) || (state == cart_pkg::st_gsu_end);

  // port takes a new request only while idle
  a_strobe_rdy: assert property (@(posedge CLK2) disable iff (reset)
    strobe |-> rdy)
    else $error("request strobe while rdy is low");

  // write enable only inside a write access with a write pending
  a_we_state: assert property (@(posedge CLK2) disable iff (reset)
    !we_n |-> wr_state && wr_pend)
    else $error("rom_we_n low outside a write state");

  // grant, seven access cycles, end state, then rdy
  a_cycle_len: assert property (@(posedge CLK2) disable iff (reset)
    (state != cart_pkg::st_idle && $past(state) == cart_pkg::st_idle) |-> ##7 end_state)
    else $error("rom cycle length wrong, rdy not 9 cycles after grant");

endmodule

// port side, fsm inputs tied to quiet values
bind rom_req_port cart_main_sva u_port_sva (
  .CLK2    (CLK2),
  .reset   (reset),
  .strobe  (req.rrq | req.wrq),
  .rdy     (rdy),
  .state   (cart_pkg::st_idle),
  .we_n    (1'b1),
  .wr_pend (pend.wr_pend)
);

bind rom_cycle_fsm cart_main_sva u_fsm_sva (
  .CLK2    (CLK2),
  .reset   (reset),
  .strobe  (1'b0),
  .rdy     (1'b1),
  .state   (state_q),
  .we_n    (rom_we_n),
  .wr_pend (mcu_pend.wr_pend | gsu_pend.wr_pend)
);

// ==== bench/tb_cart_main.sv ====
`timescale 1ns/1ps

module tb_cart_main;

  localparam int num_tests   = 40;
  localparam int tb_dead     = 40;
  localparam int rdy_timeout = 200;

  logic                            CLK2 = 1'b0;
  logic                            reset;
  logic [cart_pkg::snes_addr_w-1:0] snes_addr;
  logic                            snes_cpu_clk = 1'b0;
  logic                            snes_rd_n;
  logic                            snes_wr_n;
  logic                            rom_hit;
  cart_pkg::rom_req_t              mcu_req;
  cart_pkg::rom_req_t              gsu_req;
  logic                            gsu_active;
  cart_pkg::rom_word_t             rom_rdata;
  cart_pkg::byte_t                 snes_rdata;
  logic                            snes_reset_strobe;
  logic                            mcu_rdy;
  logic                            gsu_rdy;
  cart_pkg::byte_t                 mcu_rdata;
  cart_pkg::byte_t                 gsu_rdata;
  logic [cart_pkg::rom_addr_w-1:0] rom_addr;
  cart_pkg::rom_word_t             rom_wdata;
  logic                            rom_wdata_en;
  logic                            rom_we_n;
  logic                            rom_bhe_n;
  logic                            rom_ble_n;

  cart_pkg::rom_word_t rom_mem [256];
  cart_pkg::byte_t     shadow [512];
  // bit 8 marks a read whose byte gets checked
  logic [8:0]          exp_mcu_q [$];
  logic [8:0]          exp_gsu_q [$];
  logic [8:0]          exp_mcu;
  logic [8:0]          exp_gsu;
  logic                mcu_rdy_d;
  logic                gsu_rdy_d;
  int                  err_cnt = 0;
  int                  chk_cnt = 0;
  int                  strobe_cnt;
  int                  fall_cnt = 0;
  int                  half_cnt = 0;
  logic                cpu_run = 1'b0;
  integer              seed = 64513;

  always #10 CLK2 = ~CLK2;

  cart_main #(
    .dead_timeout (tb_dead),
    .sync_depth   (8)
  ) dut (
    .CLK2              (CLK2),
    .reset             (reset),
    .snes_addr         (snes_addr),
    .snes_cpu_clk      (snes_cpu_clk),
    .snes_rd_n         (snes_rd_n),
    .snes_wr_n         (snes_wr_n),
    .rom_hit           (rom_hit),
    .snes_rdata        (snes_rdata),
    .snes_reset_strobe (snes_reset_strobe),
    .mcu_req           (mcu_req),
    .gsu_req           (gsu_req),
    .gsu_active        (gsu_active),
    .mcu_rdy           (mcu_rdy),
    .gsu_rdy           (gsu_rdy),
    .mcu_rdata         (mcu_rdata),
    .gsu_rdata         (gsu_rdata),
    .rom_rdata         (rom_rdata),
    .rom_addr          (rom_addr),
    .rom_wdata         (rom_wdata),
    .rom_wdata_en      (rom_wdata_en),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n)
  );

  ////////////////////////////////////////
  // rom model
  ////////////////////////////////////////

  // fill pattern from the full word index
  function automatic cart_pkg::rom_word_t fill_word(input int w);
    return {w[7:0] ^ 8'ha5, w[7:0] + 8'h31};
  endfunction

  assign rom_rdata = rom_mem[rom_addr[7:0]];

  // only the enabled lane gets written
  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      if (!rom_ble_n) begin
        rom_mem[rom_addr[7:0]][7:0] <= rom_wdata[7:0];
      end
      if (!rom_bhe_n) begin
        rom_mem[rom_addr[7:0]][15:8] <= rom_wdata[15:8];
      end
    end
  end

  // odd byte address lives in the low lane
  function automatic cart_pkg::byte_t ref_byte(input logic [23:0] addr);
    return shadow[addr[8:0]];
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_byte(input string name, input cart_pkg::byte_t got,
                            input cart_pkg::byte_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // compare read data on every rise of rdy
  always @(negedge CLK2) begin
    mcu_rdy_d <= mcu_rdy;
    gsu_rdy_d <= gsu_rdy;
    if (!reset && mcu_rdy && mcu_rdy_d === 1'b0) begin
      if (exp_mcu_q.size() == 0) begin
        err_cnt++;
        $display("mcu_rdy rose with no mcu request outstanding");
      end else begin
        exp_mcu = exp_mcu_q.pop_front();
        if (exp_mcu[8]) check_byte("mcu_rdata", mcu_rdata, exp_mcu[7:0]);
      end
    end
    if (!reset && gsu_rdy && gsu_rdy_d === 1'b0) begin
      if (exp_gsu_q.size() == 0) begin
        err_cnt++;
        $display("gsu_rdy rose with no gsu request outstanding");
      end else begin
        exp_gsu = exp_gsu_q.pop_front();
        if (exp_gsu[8]) check_byte("gsu_rdata", gsu_rdata, exp_gsu[7:0]);
      end
    end
  end

  ////////////////////////////////////////
  // snes clock and strobe monitor
  ////////////////////////////////////////

  // cpu clock, 6 high and 6 low cycles
  always @(posedge CLK2) begin
    if (reset || !cpu_run) begin
      snes_cpu_clk <= 1'b0;
      half_cnt     <= 0;
    end else if (half_cnt == 5) begin
      half_cnt     <= 0;
      snes_cpu_clk <= ~snes_cpu_clk;
      if (snes_cpu_clk) fall_cnt <= fall_cnt + 1;
    end else begin
      half_cnt <= half_cnt + 1;
    end
  end

  always @(posedge CLK2) begin
    if (reset) begin
      strobe_cnt <= 0;
    end else if (snes_reset_strobe) begin
      strobe_cnt <= strobe_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // request helpers
  ////////////////////////////////////////

  // sets one strobe, caller sits on a rising edge
  task automatic drive_req(input logic gsu, input logic is_wr, input logic [23:0] addr,
                           input cart_pkg::byte_t wdata);
    logic [8:0] exp;
    if (is_wr) begin
      shadow[addr[8:0]] = wdata;
      exp = 9'h000;
    end else begin
      exp = {1'b1, ref_byte(addr)};
    end
    if (gsu) begin
      gsu_req.rrq   <= ~is_wr;
      gsu_req.wrq   <= is_wr;
      gsu_req.addr  <= addr;
      gsu_req.wdata <= wdata;
      exp_gsu_q.push_back(exp);
    end else begin
      mcu_req.rrq   <= ~is_wr;
      mcu_req.wrq   <= is_wr;
      mcu_req.addr  <= addr;
      mcu_req.wdata <= wdata;
      exp_mcu_q.push_back(exp);
    end
  endtask

  task automatic clear_reqs();
    mcu_req.rrq <= 1'b0;
    mcu_req.wrq <= 1'b0;
    gsu_req.rrq <= 1'b0;
    gsu_req.wrq <= 1'b0;
  endtask

  task automatic wait_ready(input logic gsu);
    int n;
    n = 0;
    @(negedge CLK2);
    while (!(gsu ? gsu_rdy : mcu_rdy) && n < rdy_timeout) begin
      @(negedge CLK2);
      n++;
    end
    if (n >= rdy_timeout) begin
      err_cnt++;
      $display("%s ready did not return within %0d cycles", gsu ? "gsu" : "mcu", rdy_timeout);
    end
  endtask

  task automatic access(input logic gsu, input logic is_wr, input logic [23:0] addr,
                        input cart_pkg::byte_t wdata);
    @(posedge CLK2);
    drive_req(gsu, is_wr, addr, wdata);
    @(posedge CLK2);
    clear_reqs();
    wait_ready(gsu);
  endtask

  // write, read back, and read the other byte of the word
  task automatic write_read_pair(input logic gsu);
    logic [23:0]     addr;
    cart_pkg::byte_t data;
    addr = 24'($random(seed)) & 24'h0001ff;
    data = 8'($random(seed));
    access(gsu, 1'b1, addr, data);
    access(gsu, 1'b0, addr, 8'h00);
    access(gsu, 1'b0, addr ^ 24'h1, 8'h00);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [23:0] addr;
    int          base;
    int          f0;
    reset      <= 1'b1;
    snes_addr  <= '0;
    snes_rd_n  <= 1'b1;
    snes_wr_n  <= 1'b1;
    rom_hit    <= 1'b0;
    mcu_req    <= '0;
    gsu_req    <= '0;
    gsu_active <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      rom_mem[i] <= fill_word(i);
    end
    for (int a = 0; a < 512; a++) begin
      shadow[a] = a[0] ? fill_word(a >> 1) & 8'hff : fill_word(a >> 1) >> 8;
    end
    repeat (3) @(posedge CLK2);
    reset <= 1'b0;

    // 1: idle values after reset
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("gsu_rdy", gsu_rdy, 1'b1);
    check_bit("rom_we_n", rom_we_n, 1'b1);
    check_bit("rom_wdata_en", rom_wdata_en, 1'b0);

    // 2: snes dead, mcu reads anywhere
    repeat (tb_dead + 10) @(posedge CLK2);
    for (int k = 0; k < 8; k++) begin
      addr = 24'($random(seed)) & 24'h0001ff;
      access(1'b0, 1'b0, addr, 8'h00);
    end

    // 3: mcu write then read back
    for (int k = 0; k < 4; k++) begin
      write_read_pair(1'b0);
    end

    // 4: gsu owns the bus
    @(posedge CLK2);
    gsu_active <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      write_read_pair(1'b1);
    end
    @(posedge CLK2);
    drive_req(1'b0, 1'b0, 24'h000031, 8'h00);
    drive_req(1'b1, 1'b0, 24'h000100, 8'h00);
    @(posedge CLK2);
    clear_reqs();
    wait_ready(1'b1);
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    @(posedge CLK2);
    gsu_active <= 1'b0;
    wait_ready(1'b0);

    // 5: live snes clock, rom cycles only after a cycle end
    @(posedge CLK2);
    base = strobe_cnt;
    rom_hit <= 1'b1;
    cpu_run <= 1'b1;
    repeat (40) @(posedge CLK2);
    check_byte("snes_reset_strobe", 8'(strobe_cnt - base), 8'h01);
    for (int k = 0; k < 2; k++) begin
      @(posedge snes_cpu_clk);
      f0 = fall_cnt;
      addr = 24'($random(seed)) & 24'h0001ff;
      access(1'b0, 1'b0, addr, 8'h00);
      check_bit("cpu cycle end before mcu_rdy", fall_cnt > f0, 1'b1);
    end
    @(posedge CLK2);
    cpu_run <= 1'b0;
    repeat (tb_dead + 20) @(posedge CLK2);
    base = strobe_cnt;
    cpu_run <= 1'b1;
    repeat (40) @(posedge CLK2);
    check_byte("snes_reset_strobe", 8'(strobe_cnt - base), 8'h01);

    // idle rom bus follows the snes address
    addr = 24'($random(seed)) & 24'h0001ff;
    snes_addr <= addr;
    repeat (10) @(posedge CLK2);
    @(negedge CLK2);
    check_byte("snes_rdata", snes_rdata, ref_byte(addr));
    @(posedge CLK2);
    cpu_run <= 1'b0;
    repeat (5) @(posedge CLK2);

    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // run limit scales with the number of requests
  initial begin
    repeat (num_tests * 200) @(posedge CLK2);
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== cart_main.f ====
hw/cart_pkg.sv
hw/snes_bus_sync.sv
hw/rom_req_port.sv
hw/rom_cycle_fsm.sv
hw/cart_main.sv
bench/cart_main_sva.sv
bench/tb_cart_main.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cart_main testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cart_main \
  -Mdir obj_dir \
  -f cart_main.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cart_main > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$log"; then
  exit 0
fi
exit 1
